/* Makefile */
# Verilator build and run for the st core glue testbench

VERILATOR ?= verilator
TOP       ?= st_core_glue_tb
FILELIST  ?= st_core_glue.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verification/*.svh)
SIM     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD)

/* hw/audio_volume.sv */
// ##########################################################
// stereo audio sign extension and osd volume scaling
// ##########################################################

module audio_volume (
  input  logic                     clk32,
  input  logic                     rst_n,
  input  st_glue_pkg::volume_e     volume,
  input  st_glue_pkg::audio_raw_t  audio_l,
  input  st_glue_pkg::audio_raw_t  audio_r,
  output st_glue_pkg::audio_pair_t audio
);

  st_glue_pkg::audio_pair_t audio_nxt;

  // widen to 16 bit, then divide by shifting, sign kept
  function automatic st_glue_pkg::audio_t scale(
    input st_glue_pkg::audio_raw_t raw,
    input st_glue_pkg::volume_e    vol
  );
    st_glue_pkg::audio_t ext;
    ext = {raw[14], raw};   // sign extend
    case (vol)
      st_glue_pkg::vol_mute:    scale = '0;
      st_glue_pkg::vol_quarter: scale = ext >>> 2;
      st_glue_pkg::vol_half:    scale = ext >>> 1;
      default:                  scale = ext;   // full
    endcase
  endfunction

  assign audio_nxt.l = scale(audio_l, volume);
  assign audio_nxt.r = scale(audio_r, volume);

  always_ff @(posedge clk32 or negedge rst_n) begin
    if (!rst_n)
      audio <= '0;   // silence
    else
      audio <= audio_nxt;
  end

endmodule

/* hw/boot_gate.sv */
// ##########################################################
// wait for a mounted disk image or timeout, then
// combine all ready and reset terms into chipset reset
// ##########################################################

module boot_gate #(
  parameter int unsigned boot_wait_cycles = st_glue_pkg::boot_wait_default
) (
  input  logic        clk32,
  input  logic        rst_n,
  input  logic        reset_req,      // osd reset
  input  logic        reset_button,   // board button, active high
  input  logic        ram_ready,
  input  logic        flash_ready,
  input  logic [31:0] img_size,       // 0 until the mcu mounts an image
  output logic        chipset_resb
);

  st_glue_pkg::boot_state_e state;
  logic [31:0]              wait_cnt;
  logic                     sd_ready;
  logic                     wait_over;

  assign wait_over = (wait_cnt >= 32'(boot_wait_cycles));
  assign sd_ready  = (state == st_glue_pkg::boot_done);

  // give the mcu time to mount a default image before booting
  always_ff @(posedge clk32 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_glue_pkg::boot_waiting;
      wait_cnt <= '0;
    end else begin
      case (state)
        st_glue_pkg::boot_waiting: begin
          if (!wait_over)
            wait_cnt <= wait_cnt + 32'd1;   // saturates at the timeout
          if (img_size != 32'd0 || wait_over)
            state <= st_glue_pkg::boot_done;
        end
        default: state <= st_glue_pkg::boot_done;   // stays until reset
      endcase
    end
  end

  // chipset runs only when every source agrees
  always_ff @(posedge clk32 or negedge rst_n) begin
    if (!rst_n)
      chipset_resb <= 1'b0;
    else
      chipset_resb <= !reset_req && !reset_button && ram_ready && flash_ready && sd_ready;
  end

  // boot gating never re-arms without a reset
  a_boot_sticky: assert property (@(posedge clk32) disable iff (!rst_n)
    state == st_glue_pkg::boot_done |=> state == st_glue_pkg::boot_done);

endmodule

/* hw/joy_kbd_mapper.sv */
// ##########################################################
// joystick port routing (usb/db9) and st keyboard
// matrix scan, one registered stage
// ##########################################################

module joy_kbd_mapper (
  input  logic                     clk32,
  input  logic                     rst_n,
  input  st_glue_pkg::mouse_port_e port_mouse,
  input  st_glue_pkg::joy_t        hid_mouse,
  input  st_glue_pkg::hid_joy_t    hid_joy,
  input  st_glue_pkg::db9_raw_t    io,
  input  st_glue_pkg::kbd_matrix_t kbd_matrix,
  input  st_glue_pkg::kbd_cols_t   kbd_cols,
  output st_glue_pkg::joy_t        joy0,
  output st_glue_pkg::joy_t        joy1,
  output st_glue_pkg::kbd_row_t    kbd_rows
);

  st_glue_pkg::joy_t     db9_atari;
  st_glue_pkg::joy_t     db9_amiga;
  st_glue_pkg::joy_t     db9_joy;
  st_glue_pkg::joy_t     joy0_nxt;
  st_glue_pkg::joy_t     joy1_nxt;
  st_glue_pkg::kbd_row_t rows_nxt;

  // up and right pins trade places between atari and amiga wiring
  assign db9_atari = ~{io[5], io[0], io[2], io[1], io[4], io[3]};
  assign db9_amiga = ~{io[5], io[0], io[3], io[1], io[4], io[2]};

  // port 0 takes the mouse from usb or either db9 wiring
  always_comb begin
    case (port_mouse)
      st_glue_pkg::mouse_usb:       joy0_nxt = hid_mouse;
      st_glue_pkg::mouse_db9_atari: joy0_nxt = db9_atari;
      st_glue_pkg::mouse_db9_amiga: joy0_nxt = db9_amiga;
      default:                      joy0_nxt = '0;   // port off
    endcase
  end

  // db9 acts as joystick only while the mouse is on usb
  assign db9_joy  = (port_mouse == st_glue_pkg::mouse_usb) ? db9_atari : '0;
  assign joy1_nxt = {1'b0, hid_joy[4:0] | db9_joy[4:0]};   // no fire2 on port 1

  // AND of all rows whose column line is pulled low
  always_comb begin
    rows_nxt = '1;
    for (int i = 0; i < st_glue_pkg::kbd_cols; i++) begin
      if (!kbd_cols[i])
        rows_nxt = rows_nxt & kbd_matrix[8*i +: 8];
    end
  end

  always_ff @(posedge clk32 or negedge rst_n) begin
    if (!rst_n) begin
      joy0     <= '0;
      joy1     <= '0;
      kbd_rows <= '1;   // no key pressed
    end else begin
      joy0     <= joy0_nxt;
      joy1     <= joy1_nxt;
      kbd_rows <= rows_nxt;
    end
  end

endmodule

/* hw/ram_scrambler.sv */
// ##########################################################
// cold-boot ram address scrambling and sdram request
// ##########################################################

module ram_scrambler (
  input  logic                     clk32,
  input  logic                     rst_n,
  input  logic                     coldboot,   // osd cold boot flag
  input  st_glue_pkg::st_ram_bus_t ram_bus,
  output st_glue_pkg::sdram_req_t  sdram_req
);

  logic                        cb_q;           // coldboot, one cycle old
  logic                        cb_edge;
  logic [1:0]                  scramble_cnt;
  st_glue_pkg::ram_word_addr_t addr_s;         // scrambled chipset addr
  st_glue_pkg::sdram_req_t     req_nxt;

  assign cb_edge = coldboot && !cb_q;

  // every cold boot moves ram contents so old data is garbage
  always_ff @(posedge clk32 or negedge rst_n) begin
    if (!rst_n) begin
      cb_q         <= 1'b0;
      scramble_cnt <= 2'd0;
    end else begin
      cb_q <= coldboot;
      if (cb_edge)
        scramble_cnt <= scramble_cnt + 2'd1;
    end
  end

  always_comb begin
    addr_s = ram_bus.addr;
    addr_s[st_glue_pkg::scramble_lsb +: 2] = ram_bus.addr[st_glue_pkg::scramble_lsb +: 2]
                                             ^ scramble_cnt;
  end

  assign req_nxt.addr = addr_s[22:1];                          // bit 23 not mapped
  assign req_nxt.cs   = !ram_bus.ras_n && !ram_bus.addr[23];   // lower 8 MB only
  assign req_nxt.we   = !ram_bus.we_n;
  assign req_nxt.ds   = ~{ram_bus.cash_n, ram_bus.casl_n};

  always_ff @(posedge clk32 or negedge rst_n) begin
    if (!rst_n)
      sdram_req <= '0;   // idle, no cs/we
    else
      sdram_req <= req_nxt;
  end

  // count steps by one, and only right after a coldboot edge
  a_scramble_step: assert property (@(posedge clk32) disable iff (!rst_n)
    scramble_cnt != $past(scramble_cnt) |->
      scramble_cnt == $past(scramble_cnt) + 2'd1 && $past(cb_edge));

endmodule

/* hw/st_core_glue.sv */
// ##########################################################
// st core glue top: input mapping, audio volume,
// boot gating and ram scrambling side by side
// ##########################################################

module st_core_glue #(
  parameter int unsigned boot_wait_cycles = st_glue_pkg::boot_wait_default
) (
  input  logic                     clk32,
  input  logic                     rst_n,
  input  st_glue_pkg::sys_cfg_t    cfg,
  input  st_glue_pkg::joy_t        hid_mouse,
  input  st_glue_pkg::hid_joy_t    hid_joy,
  input  st_glue_pkg::db9_raw_t    io,
  input  st_glue_pkg::kbd_matrix_t kbd_matrix,
  input  st_glue_pkg::kbd_cols_t   kbd_cols,
  output st_glue_pkg::joy_t        joy0,
  output st_glue_pkg::joy_t        joy1,
  output st_glue_pkg::kbd_row_t    kbd_rows,
  input  st_glue_pkg::audio_raw_t  audio_l,
  input  st_glue_pkg::audio_raw_t  audio_r,
  output st_glue_pkg::audio_pair_t audio,
  input  logic                     reset_button,
  input  logic                     ram_ready,
  input  logic                     flash_ready,
  input  logic [31:0]              img_size,
  output logic                     chipset_resb,
  input  st_glue_pkg::st_ram_bus_t ram_bus,
  output st_glue_pkg::sdram_req_t  sdram_req
);

  // mouse on port 0, merged joysticks on port 1
  joy_kbd_mapper u_joy_kbd (
    .clk32      (clk32),
    .rst_n      (rst_n),
    .port_mouse (cfg.port_mouse),
    .hid_mouse  (hid_mouse),
    .hid_joy    (hid_joy),
    .io         (io),
    .kbd_matrix (kbd_matrix),
    .kbd_cols   (kbd_cols),
    .joy0       (joy0),
    .joy1       (joy1),
    .kbd_rows   (kbd_rows)
  );

  audio_volume u_audio (
    .clk32   (clk32),
    .rst_n   (rst_n),
    .volume  (cfg.volume),
    .audio_l (audio_l),
    .audio_r (audio_r),
    .audio   (audio)
  );

  boot_gate #(
    .boot_wait_cycles (boot_wait_cycles)
  ) u_boot (
    .clk32        (clk32),
    .rst_n        (rst_n),
    .reset_req    (cfg.reset_req),
    .reset_button (reset_button),
    .ram_ready    (ram_ready),
    .flash_ready  (flash_ready),
    .img_size     (img_size),
    .chipset_resb (chipset_resb)
  );

  ram_scrambler u_ram (
    .clk32     (clk32),
    .rst_n     (rst_n),
    .coldboot  (cfg.coldboot),
    .ram_bus   (ram_bus),
    .sdram_req (sdram_req)
  );

endmodule

/* hw/st_glue_pkg.sv */
// ##########################################################
// shared widths, bus structs, osd setting enums and
// constants for the st core glue logic
// ##########################################################

package st_glue_pkg;

  localparam int kbd_cols = 15;                         // st keyboard matrix columns
  localparam int unsigned boot_wait_default = 64000000; // 2 s at 32 MHz
  localparam int scramble_lsb = 3;                      // lowest scrambled ram addr bit

  // joystick: fire2, fire, up, down, left, right
  typedef logic [5:0] joy_t;
  typedef logic [7:0] hid_joy_t;                 // usb pad, four buttons
  typedef logic [7:0] db9_raw_t;                 // io pins, active low

  typedef logic [kbd_cols-1:0] kbd_cols_t;       // column select, active low
  typedef logic [7:0] kbd_row_t;                 // row response, active low
  typedef logic [kbd_cols*8-1:0] kbd_matrix_t;   // row i at [8i+7:8i]

  typedef logic signed [14:0] audio_raw_t;       // chipset mix
  typedef logic signed [15:0] audio_t;

  typedef logic [23:1] ram_word_addr_t;          // chipset word address
  typedef logic [21:0] sdram_addr_t;             // sdram word address

  typedef enum logic [1:0] {
    mouse_usb       = 2'd0,
    mouse_db9_atari = 2'd1,
    mouse_db9_amiga = 2'd2,
    mouse_none      = 2'd3
  } mouse_port_e;

  typedef enum logic [1:0] {
    vol_mute    = 2'd0,
    vol_quarter = 2'd1,
    vol_half    = 2'd2,
    vol_full    = 2'd3
  } volume_e;

  typedef enum logic [0:0] {
    boot_waiting = 1'b0,
    boot_done    = 1'b1
  } boot_state_e;

  typedef struct packed {
    audio_t l;
    audio_t r;
  } audio_pair_t;

  typedef struct packed {
    sdram_addr_t addr;
    logic        cs;
    logic        we;
    logic [1:0]  ds;     // upper, lower byte, active high
  } sdram_req_t;

  typedef struct packed {
    logic           ras_n;
    logic           cash_n;
    logic           casl_n;
    logic           we_n;
    ram_word_addr_t addr;
  } st_ram_bus_t;

  // settings set from the osd menu
  typedef struct packed {
    mouse_port_e port_mouse;
    volume_e     volume;
    logic        reset_req;
    logic        coldboot;
  } sys_cfg_t;

endpackage

/* st_core_glue.f */
+incdir+verification
hw/st_glue_pkg.sv
hw/joy_kbd_mapper.sv
hw/audio_volume.sv
hw/boot_gate.sv
hw/ram_scrambler.sv
hw/st_core_glue.sv
verification/st_core_glue_tb.sv

/* verification/st_core_glue_model.svh */
// ##########################################################
// reference model for the st glue stages and the typed
// compare tasks used by the testbench
// ##########################################################
`ifndef st_core_glue_model_svh
`define st_core_glue_model_svh

// amiga wiring swaps the up and right pins
function automatic st_glue_pkg::joy_t db9_decode(input st_glue_pkg::db9_raw_t p,
                                                 input bit amiga);
  st_glue_pkg::joy_t j;
  j[5] = ~p[5];                    // fire2
  j[4] = ~p[0];                    // fire
  j[3] = amiga ? ~p[3] : ~p[2];    // up
  j[2] = ~p[1];                    // down
  j[1] = ~p[4];                    // left
  j[0] = amiga ? ~p[2] : ~p[3];    // right
  return j;
endfunction

function automatic st_glue_pkg::joy_t route_joy0(input st_glue_pkg::mouse_port_e port,
                                                 input st_glue_pkg::joy_t mouse,
                                                 input st_glue_pkg::db9_raw_t pins);
  if (port == st_glue_pkg::mouse_usb)
    return mouse;
  if (port == st_glue_pkg::mouse_db9_atari)
    return db9_decode(pins, 1'b0);
  if (port == st_glue_pkg::mouse_db9_amiga)
    return db9_decode(pins, 1'b1);
  return '0;   // mouse_none
endfunction

// usb pad ORed with the db9 stick while the mouse is on usb
function automatic st_glue_pkg::joy_t merge_joy1(input st_glue_pkg::mouse_port_e port,
                                                 input st_glue_pkg::hid_joy_t pad,
                                                 input st_glue_pkg::db9_raw_t pins);
  st_glue_pkg::joy_t stick;
  stick = (port == st_glue_pkg::mouse_usb) ? db9_decode(pins, 1'b0) : '0;
  return {1'b0, pad[4:0] | stick[4:0]};
endfunction

// a pressed key in any selected column pulls its row bit low
function automatic st_glue_pkg::kbd_row_t scan_rows(input st_glue_pkg::kbd_matrix_t m,
                                                    input st_glue_pkg::kbd_cols_t cols);
  st_glue_pkg::kbd_row_t r;
  r = '1;   // idle high
  for (int b = 0; b < 8; b++)
    for (int i = 0; i < st_glue_pkg::kbd_cols; i++)
      if (cols[i] == 1'b0 && m[8*i + b] == 1'b0)
        r[b] = 1'b0;
  return r;
endfunction

function automatic st_glue_pkg::audio_t scale_audio(input st_glue_pkg::audio_raw_t raw,
                                                    input st_glue_pkg::volume_e vol);
  int s;
  s = int'(raw);   // signed widen
  case (vol)
    st_glue_pkg::vol_mute:    return '0;
    st_glue_pkg::vol_quarter: return st_glue_pkg::audio_t'(s >>> 2);
    st_glue_pkg::vol_half:    return st_glue_pkg::audio_t'(s >>> 1);
    default:                  return st_glue_pkg::audio_t'(s);
  endcase
endfunction

function automatic st_glue_pkg::sdram_req_t scramble_req(input st_glue_pkg::st_ram_bus_t bus,
                                                         input logic [1:0] cnt);
  st_glue_pkg::sdram_req_t r;
  r.addr      = bus.addr[22:1];
  r.addr[3:2] = r.addr[3:2] ^ cnt;   // ram bits 4:3 sit at word bits 3:2
  r.cs        = !bus.ras_n && !bus.addr[23];
  r.we        = !bus.we_n;
  r.ds        = {!bus.cash_n, !bus.casl_n};
  return r;
endfunction

task automatic check_joy(input string name, input st_glue_pkg::joy_t got,
                         input st_glue_pkg::joy_t exp);
  if (got !== exp)
    report_fail($sformatf("%s got %b expected %b", name, got, exp));
endtask

task automatic check_kbd_row(input st_glue_pkg::kbd_row_t got, input st_glue_pkg::kbd_row_t exp);
  if (got !== exp)
    report_fail($sformatf("kbd_rows got %h expected %h", got, exp));
endtask

task automatic check_audio(input st_glue_pkg::audio_pair_t got,
                           input st_glue_pkg::audio_pair_t exp);
  if (got !== exp)
    report_fail($sformatf("audio got %h/%h expected %h/%h", got.l, got.r, exp.l, exp.r));
endtask

task automatic check_sdram_req(input st_glue_pkg::sdram_req_t got,
                               input st_glue_pkg::sdram_req_t exp);
  if (got !== exp)
    report_fail($sformatf("sdram_req got %h expected %h", got, exp));
endtask

task automatic check_resb(input logic got, input logic exp);
  if (got !== exp)
    report_fail($sformatf("chipset_resb got %b expected %b", got, exp));
endtask

`endif

/* verification/st_core_glue_tb.sv */
// ##########################################################
// testbench with clock, reset, random stimulus,
// two boot gating runs and a cycle limit
// ##########################################################

module st_core_glue_tb;

  localparam int boot_cycles    = 300;
  localparam int rand_cycles    = 1000;
  localparam int timeout_cycles = 4 * (rand_cycles + boot_cycles);

  logic                     clk32;
  logic                     rst_n;
  st_glue_pkg::sys_cfg_t    cfg;
  st_glue_pkg::joy_t        hid_mouse;
  st_glue_pkg::hid_joy_t    hid_joy;
  st_glue_pkg::db9_raw_t    io;
  st_glue_pkg::kbd_matrix_t kbd_matrix;
  st_glue_pkg::kbd_cols_t   kbd_cols;
  st_glue_pkg::joy_t        joy0;
  st_glue_pkg::joy_t        joy1;
  st_glue_pkg::kbd_row_t    kbd_rows;
  st_glue_pkg::audio_raw_t  audio_l;
  st_glue_pkg::audio_raw_t  audio_r;
  st_glue_pkg::audio_pair_t audio;
  logic                     reset_button;
  logic                     ram_ready;
  logic                     flash_ready;
  logic [31:0]              img_size;
  logic                     chipset_resb;
  st_glue_pkg::st_ram_bus_t ram_bus;
  st_glue_pkg::sdram_req_t  sdram_req;

  // expected outputs for the next edge
  st_glue_pkg::joy_t        exp_joy0;
  st_glue_pkg::joy_t        exp_joy1;
  st_glue_pkg::kbd_row_t    exp_rows;
  st_glue_pkg::audio_pair_t exp_audio;
  st_glue_pkg::sdram_req_t  exp_req;
  logic                     exp_resb;
  logic [1:0]               model_cnt;   // scramble count
  logic                     model_cb_q;  // coldboot seen at last edge
  int                       cycle_cnt = 0;

  st_core_glue #(.boot_wait_cycles(200)) dut (.*);

  initial begin
    clk32 = 1'b0;
    forever #20 clk32 = ~clk32;
  end

  always @(posedge clk32) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic report_fail(input string msg);
    $display("FAIL @ %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first mismatch");
  endtask

  `include "st_core_glue_model.svh"

  // random inputs plus the outputs they give at the next edge
  task automatic drive_random(input bit ctl_rand);
    cfg.port_mouse = st_glue_pkg::mouse_port_e'(2'($urandom));
    cfg.volume     = st_glue_pkg::volume_e'(2'($urandom));
    cfg.coldboot   = ($urandom_range(5) == 0);   // short pulses
    cfg.reset_req  = ctl_rand && ($urandom_range(9) == 0);
    reset_button   = ctl_rand && ($urandom_range(9) == 0);
    ram_ready      = !(ctl_rand && ($urandom_range(9) == 0));
    flash_ready    = !(ctl_rand && ($urandom_range(9) == 0));
    hid_mouse      = st_glue_pkg::joy_t'($urandom);
    hid_joy        = st_glue_pkg::hid_joy_t'($urandom);
    io             = st_glue_pkg::db9_raw_t'($urandom);
    kbd_matrix     = {$urandom, $urandom, $urandom, 24'($urandom)};
    case ($urandom_range(3))
      0:       kbd_cols = '1;                              // no column
      1:       kbd_cols = ~(15'd1 << $urandom_range(14));  // single column
      default: kbd_cols = st_glue_pkg::kbd_cols_t'($urandom);
    endcase
    audio_l = st_glue_pkg::audio_raw_t'($urandom);
    audio_r = st_glue_pkg::audio_raw_t'($urandom);
    ram_bus = st_glue_pkg::st_ram_bus_t'(27'($urandom));
    exp_joy0    = route_joy0(cfg.port_mouse, hid_mouse, io);
    exp_joy1    = merge_joy1(cfg.port_mouse, hid_joy, io);
    exp_rows    = scan_rows(kbd_matrix, kbd_cols);
    exp_audio.l = scale_audio(audio_l, cfg.volume);
    exp_audio.r = scale_audio(audio_r, cfg.volume);
    exp_resb    = !cfg.reset_req && !reset_button && ram_ready && flash_ready;
    exp_req     = scramble_req(ram_bus, model_cnt);   // old count at the edge
    if (cfg.coldboot && !model_cb_q)
      model_cnt = model_cnt + 2'd1;
    model_cb_q = cfg.coldboot;
  endtask

  // check the outputs of edge k after release, then drive again
  task automatic run_cycle(input int k, input int low_until, input int exact_from,
                           input bit ctl_rand);
    @(posedge clk32);
    #2;
    check_joy("joy0", joy0, exp_joy0);
    check_joy("joy1", joy1, exp_joy1);
    check_kbd_row(kbd_rows, exp_rows);
    check_audio(audio, exp_audio);
    check_sdram_req(sdram_req, exp_req);
    if (k < low_until)
      check_resb(chipset_resb, 1'b0);   // still gated
    else if (k >= exact_from)
      check_resb(chipset_resb, exp_resb);
    drive_random(ctl_rand);
  endtask

  task automatic apply_reset(input logic [31:0] img);
    rst_n    = 1'b0;
    img_size = 32'd0;
    repeat (8) @(posedge clk32);
    #2;
    check_joy("joy0 in reset", joy0, '0);
    check_joy("joy1 in reset", joy1, '0);
    check_kbd_row(kbd_rows, '1);
    check_audio(audio, '0);
    check_resb(chipset_resb, 1'b0);
    if (sdram_req.cs || sdram_req.we)
      report_fail("sdram cs or we active during reset");
    model_cnt  = 2'd0;
    model_cb_q = 1'b0;
    img_size   = img;
    rst_n      = 1'b1;
    drive_random(1'b0);
  endtask

  initial begin
    void'($urandom(46262));
    rst_n        = 1'b0;
    cfg          = '0;
    hid_mouse    = '0;
    hid_joy      = '0;
    io           = '1;   // db9 idle
    kbd_matrix   = '1;
    kbd_cols     = '1;
    audio_l      = '0;
    audio_r      = '0;
    reset_button = 1'b0;
    ram_ready    = 1'b0;
    flash_ready  = 1'b0;
    img_size     = 32'd0;
    ram_bus      = '1;
    // first run without an image takes the timeout path
    // reset and ready terms stay clean until edge 210
    apply_reset(32'd0);
    for (int k = 1; k <= boot_cycles; k++)
      run_cycle(k, 200, 203, k >= 210);
    // run 2 image mounted at release
    apply_reset($urandom | 32'd1);
    for (int k = 1; k <= rand_cycles; k++)
      run_cycle(k, 2, 2, k >= 5);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
